//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f list.f --top-module procTb -o procSim
	-./obj_dir/procSim > sim.log 2>&1
	@grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- list.f
source/procPkg.sv
source/fetchControl.sv
source/decode.sv
source/execute.sv
source/resultStage.sv
source/proc.sv
sim/apbMemModel.sv
sim/procTb.sv

//--- sim/apbMemModel.sv
// ==========================================================================
// APB slave memory with random wait states
// ==========================================================================
module apbMemModel (
    input  logic        clk,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] paddr,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        pready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] mem [256];
    logic [31:0] rngState;
    logic [1:0]  waitLeft;          // Access cycles still held low

    function automatic logic [15:0] randWord();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState[31:16];
    endfunction

    assign prdata = mem[paddr[7:0]];    // Word address wraps at 256

    initial begin
        rngState = 32'hdc47_f3f9;
        pready   = 1'b0;
        waitLeft = 2'd0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = {8'(a) ^ 8'ha5, 8'(a) * 8'd37 + 8'd11};
        end
    end

    // Responds on the falling edge
    always @(negedge clk) begin
        if (psel && !penable) begin
            waitLeft = 2'(randWord() % 4);  // 0 to 3 low cycles
            pready   = 1'b0;
        end else if (psel && penable) begin
            if (waitLeft == 2'd0) begin
                if (pwrite) begin
                    mem[paddr[7:0]] = pwdata;   // Completes at next rising edge
                end
                pready = 1'b1;
            end else begin
                waitLeft = waitLeft - 2'd1;
                pready   = 1'b0;
            end
        end else begin
            pready = 1'b0;
        end
    end

endmodule

//--- sim/procTb.sv
// ==========================================================================
// Processor core testbench
// ==========================================================================
module procTb;
    timeunit 1ns;
    timeprecision 1ps;
    import procPkg::*;

    localparam logic [15:0] resetPcVal = 16'h0000;
    localparam int randomCount   = 64;
    localparam int progLen       = randomCount + 9;     // Plus 8 stores and HALT
    localparam int timeoutCycles = progLen * 9 * 2 + 200;

    logic        clk;
    logic        rst;
    logic [15:0] instrAddr;
    logic [15:0] instr;
    logic [15:0] paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic        pready;
    logic        halted;
    logic        err;

    logic [15:0] prog [256];
    logic [15:0] modelMem [256];
    logic [31:0] rngState;
    logic [7:0]  expAddr [$];       // Expected APB transfers in order
    logic        expWrite [$];
    logic [15:0] expData [$];
    logic [15:0] pcTrace [$];       // Expected fetch addresses after the first
    logic [15:0] lastAddr;
    logic [7:0]  curAddr;
    logic        curWrite;
    logic [15:0] curData;
    logic        prevSetup;
    logic        prevSel;
    int          cycles;

    proc #(.resetPc(resetPcVal)) uut (
        .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .halted(halted), .err(err)
    );

    apbMemModel memInst (
        .clk(clk), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    assign instr = prog[instrAddr[7:0]];    // Same-cycle instruction port

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] randWord();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState[31:16];
    endfunction

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    // Random body, then stores of every register and HALT
    task automatic buildRandomProgram();
        int          sel;
        logic [15:0] w;
        logic [7:0]  off;
        for (int i = 0; i < 256; i++) prog[i] = 16'h0000;
        for (int i = 0; i < randomCount; i++) begin
            sel = randWord() % 8;
            w   = randWord();
            case (sel)
                0:       w[15:11] = opAlu;
                1:       w[15:11] = opAddi;
                2:       w[15:11] = opLbi;
                3:       w[15:11] = opLd;
                4:       w[15:11] = opSt;
                5:       w[15:11] = opBeqz;
                6:       w[15:11] = opBnez;
                default: w[15:11] = opJ;
            endcase
            if (sel >= 5) begin
                off     = 8'(randWord() % (randomCount - i));  // Lands at most on the stores
                w[7:0]  = off;
            end
            prog[i] = w;
        end
        for (int k = 0; k < 8; k++) begin
            prog[randomCount + k] = {opSt, 3'd0, 3'd0, 3'(k), 2'b00};
        end
        prog[randomCount + 8] = {opHalt, 11'd0};
    endtask

    // Instruction-set model of the whole program
    task automatic runModel();
        logic [15:0] r [8];
        logic [15:0] pc;
        logic [15:0] w;
        logic [15:0] nx;
        logic [15:0] i8;
        logic [15:0] i5;
        logic [15:0] a;
        int          rd;
        int          rs;
        int          rt;
        bit          done;
        for (int k = 0; k < 8; k++) r[k] = 16'h0000;
        for (int k = 0; k < 256; k++) modelMem[k] = {8'(k) ^ 8'ha5, 8'(k) * 8'd37 + 8'd11};
        expAddr.delete();
        expWrite.delete();
        expData.delete();
        pcTrace.delete();
        pc   = resetPcVal;
        done = 0;
        while (!done) begin
            w  = prog[pc[7:0]];
            rd = w[10:8];
            rs = w[7:5];
            rt = w[4:2];
            i8 = {{8{w[7]}}, w[7:0]};
            i5 = {{11{w[4]}}, w[4:0]};
            nx = pc + 16'd1;
            a  = r[rs] + i5;
            case (w[15:11])
                opAlu: begin
                    case (w[1:0])
                        fnAdd:   r[rd] = r[rs] + r[rt];
                        fnSub:   r[rd] = r[rs] - r[rt];
                        fnAnd:   r[rd] = r[rs] & r[rt];
                        default: r[rd] = r[rs] ^ r[rt];
                    endcase
                end
                opAddi: r[rd] = a;
                opLbi:  r[rd] = i8;
                opLd: begin
                    expAddr.push_back(a[7:0]);
                    expWrite.push_back(1'b0);
                    expData.push_back(16'h0000);
                    r[rd] = modelMem[a[7:0]];
                end
                opSt: begin
                    expAddr.push_back(a[7:0]);
                    expWrite.push_back(1'b1);
                    expData.push_back(r[rt]);
                    modelMem[a[7:0]] = r[rt];
                end
                opBeqz: if (r[rs] == 16'h0000) nx = pc + 16'd1 + i8;
                opBnez: if (r[rs] != 16'h0000) nx = pc + 16'd1 + i8;
                opJ:    nx = pc + 16'd1 + i8;
                default: done = 1;          // HALT or illegal stops here
            endcase
            r[0] = 16'h0000;
            if (!done) begin
                pcTrace.push_back(nx);
                pc = nx;
            end
        end
    endtask

    // Fetch trace and APB protocol monitor
    always @(negedge clk) begin
        if (rst) begin
            lastAddr  = resetPcVal;
            prevSetup = 1'b0;
            prevSel   = 1'b0;
        end else begin
            if (instrAddr != lastAddr) begin
                assert (pcTrace.size() > 0 && instrAddr == pcTrace[0])
                    else reportMismatch($sformatf("fetch address %h not expected", instrAddr));
                void'(pcTrace.pop_front());
                lastAddr = instrAddr;
            end
            assert (!(penable && !psel)) else reportMismatch("penable without psel");
            if (prevSetup) begin
                assert (psel && penable) else reportMismatch("setup not followed by access");
            end
            if (psel && !penable) begin
                assert (expAddr.size() > 0) else reportFailure("Unexpected APB transfer");
                assert (paddr[7:0] == expAddr[0] && pwrite == expWrite[0]
                        && (!pwrite || pwdata == expData[0]))
                    else reportMismatch($sformatf("APB addr %h write %b data %h, expected %h %b %h",
                        paddr, pwrite, pwdata, expAddr[0], expWrite[0], expData[0]));
                curAddr  = expAddr.pop_front();
                curWrite = expWrite.pop_front();
                curData  = expData.pop_front();
            end
            if (psel && penable) begin
                assert (prevSel) else reportMismatch("access without a preceding setup");
                assert (paddr[7:0] == curAddr && pwrite == curWrite
                        && (!curWrite || pwdata == curData))
                    else reportMismatch("APB signals changed during access");
            end
            if (halted) begin
                assert (!psel) else reportFailure("APB activity after halt");
            end
            prevSetup = psel && !penable;
            prevSel   = psel;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeoutCycles) begin
            $display("Timeout: core did not halt within %0d cycles", timeoutCycles);
            $display("Errors found");
            $fatal(1, "run stopped");
        end
    end

    task automatic releaseReset();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        assert (!psel && !penable && !halted && !err && instrAddr == resetPcVal)
            else reportMismatch("outputs not in reset state");
    endtask

    initial begin
        rst      = 1'b1;
        cycles   = 0;
        rngState = 32'hdc47_f3f9;
        buildRandomProgram();
        runModel();
        releaseReset();
        while (!halted) @(negedge clk);
        repeat (10) @(negedge clk);
        assert (!err) else reportFailure("err raised on a legal program");
        assert (expAddr.size() == 0 && pcTrace.size() == 0)
            else reportFailure("Core halted before finishing the program");

        // Second run stops on an illegal opcode
        rst = 1'b1;
        for (int i = 0; i < 256; i++) prog[i] = 16'h0000;
        prog[0] = {opLbi, 3'd1, 8'd5};
        prog[1] = {opAddi, 3'd2, 3'd1, 5'd1};
        prog[2] = {5'b11111, 11'd0};
        runModel();
        releaseReset();
        while (!halted) @(negedge clk);
        repeat (10) @(negedge clk);
        assert (err && halted && pcTrace.size() == 0 && instrAddr == 16'd2)
            else reportMismatch("illegal opcode did not stop the core with err");
        $display("No errors");
        $finish;
    end

endmodule

//--- source/decode.sv
// ==========================================================================
// Instruction decode and register file
// ==========================================================================
module decode (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [procPkg::wordWidth-1:0]     instrReg,
    input  procPkg::procState_t               state,
    input  logic [procPkg::wordWidth-1:0]     wbData,
    input  logic                              wbEn,
    output procPkg::opcode_t                  opcode,
    output procPkg::aluFunct_t                funct,
    output logic [procPkg::wordWidth-1:0]     rsVal,
    output logic [procPkg::wordWidth-1:0]     rtVal,
    output logic [procPkg::wordWidth-1:0]     imm,
    output logic [procPkg::regAddrWidth-1:0]  destReg,
    output logic                              isMem,
    output logic                              isStore,
    output logic                              isBranch,
    output logic                              isJump,
    output logic                              isHalt,
    output logic                              illegal
);
    import procPkg::*;

    logic [wordWidth-1:0]    regs [regCount];
    logic [regAddrWidth-1:0] rsIdx;
    logic [regAddrWidth-1:0] rtIdx;
    logic                    useImm5;       // Base plus short offset forms

    // Fixed field positions
    assign opcode  = opcode_t'(instrReg[15:11]);
    assign funct   = aluFunct_t'(instrReg[1:0]);
    assign destReg = instrReg[10:8];
    assign rsIdx   = instrReg[7:5];
    assign rtIdx   = instrReg[4:2];

    // Class flags from opcode only
    always_comb begin
        isMem    = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        isHalt   = 1'b0;
        illegal  = 1'b0;
        useImm5  = 1'b0;
        case (opcode)
            opAlu, opLbi: ;                     // Plain register writers
            opAddi:       useImm5 = 1'b1;
            opLd: begin
                isMem   = 1'b1;
                useImm5 = 1'b1;
            end
            opSt: begin
                isMem   = 1'b1;
                isStore = 1'b1;
                useImm5 = 1'b1;
            end
            opBeqz, opBnez: isBranch = 1'b1;
            opJ:            isJump   = 1'b1;
            opHalt:         isHalt   = 1'b1;
            default:        illegal  = 1'b1;    // Unassigned opcode
        endcase
    end

    // Sign extension, 5-bit or 8-bit
    assign imm = useImm5 ? {{(wordWidth-5){instrReg[4]}}, instrReg[4:0]}
                         : {{(wordWidth-8){instrReg[7]}}, instrReg[7:0]};

    // Register file, r0 never written so reads zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && destReg != '0) begin
            regs[destReg] <= wbData;
        end
    end

    // Operand latch at end of decode
    always_ff @(posedge clk) begin
        if (state == stDecode) begin
            rsVal <= regs[rsIdx];
            rtVal <= regs[rtIdx];
        end
    end

endmodule

//--- source/execute.sv
// ==========================================================================
// ALU and branch unit
// ==========================================================================
module execute (
    input  logic                           clk,
    input  logic                           rst,
    input  procPkg::procState_t            state,
    input  procPkg::opcode_t               opcode,
    input  procPkg::aluFunct_t             funct,
    input  logic [procPkg::wordWidth-1:0]  rsVal,
    input  logic [procPkg::wordWidth-1:0]  rtVal,
    input  logic [procPkg::wordWidth-1:0]  imm,
    input  logic [procPkg::wordWidth-1:0]  pc,
    output logic [procPkg::wordWidth-1:0]  aluOut,
    output logic                           branchTaken,
    output logic [procPkg::wordWidth-1:0]  branchTarget
);
    import procPkg::*;

    logic [wordWidth-1:0] opB;          // Second ALU operand
    logic [wordWidth-1:0] aluResult;
    logic                 condMet;

    assign opB = (opcode == opAlu) ? rtVal : imm;   // Register form vs immediate

    always_comb begin
        case (opcode)
            opAlu: begin
                case (funct)
                    fnAdd:   aluResult = rsVal + opB;
                    fnSub:   aluResult = rsVal - opB;
                    fnAnd:   aluResult = rsVal & opB;
                    fnXor:   aluResult = rsVal ^ opB;
                    default: aluResult = rsVal + opB;
                endcase
            end
            opLbi:   aluResult = imm;           // Immediate passes straight through
            default: aluResult = rsVal + opB;   // ADDI and effective address for LD/ST
        endcase
    end

    // Zero test on rs
    always_comb begin
        case (opcode)
            opBeqz:  condMet = (rsVal == '0);
            opBnez:  condMet = (rsVal != '0);
            default: condMet = 1'b0;
        endcase
    end

    // Relative to the following word
    assign branchTarget = pc + 1'b1 + imm;

    always_ff @(posedge clk) begin
        if (state == stExecute) begin
            aluOut <= aluResult;            // Held through memory and writeback
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            branchTaken <= 1'b0;
        end else if (state == stExecute) begin
            branchTaken <= condMet;         // Consumed by PC update in writeback
        end
    end

endmodule

//--- source/fetchControl.sv
// ==========================================================================
// PC, instruction register and sequencer
// ==========================================================================
module fetchControl #(
    parameter logic [procPkg::wordWidth-1:0] resetPc = '0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [procPkg::wordWidth-1:0]  instr,
    input  logic                           branchTaken,
    input  logic [procPkg::wordWidth-1:0]  branchTarget,
    input  logic                           isMem,
    input  logic                           isJump,
    input  logic                           illegal,
    input  logic                           isHalt,
    input  logic                           memDone,
    output logic [procPkg::wordWidth-1:0]  instrAddr,
    output logic [procPkg::wordWidth-1:0]  instrReg,
    output procPkg::procState_t            state,
    output logic                           halted,
    output logic                           err
);
    import procPkg::*;

    logic [wordWidth-1:0] pc;         // Word address of current instruction
    procState_t           nextState;

    assign instrAddr = pc;                      // Fetch port always shows PC
    assign halted    = (state == stHalted);

    // Sequencer next state
    always_comb begin
        nextState = state;
        case (state)
            stFetch:     nextState = stDecode;
            stDecode:    nextState = (isHalt || illegal) ? stHalted : stExecute;
            stExecute:   nextState = isMem ? stMemory : stWriteback;  // Skip memory if unused
            stMemory: begin
                if (memDone) begin                                  // Held by pready
                    nextState = stWriteback;
                end
            end
            stWriteback: nextState = stFetch;
            stHalted:    nextState = stHalted;                      // Only reset leaves
            default:     nextState = stHalted;                      // Unused encodings park
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stFetch;
            pc    <= resetPc;
            err   <= 1'b0;
        end else begin
            state <= nextState;
            if (state == stWriteback) begin
                // Taken branch or jump, else sequential
                if (branchTaken || isJump) begin
                    pc <= branchTarget;
                end else begin
                    pc <= pc + 1'b1;
                end
            end
            if (state == stDecode && illegal) begin
                err <= 1'b1;                        // Sticky until reset
            end
        end
    end

    // Instruction port answers in the same cycle
    always_ff @(posedge clk) begin
        if (state == stFetch) begin
            instrReg <= instr;
        end
    end

endmodule

//--- source/proc.sv
// ==========================================================================
// Multicycle processor top level
// ==========================================================================
module proc #(
    parameter logic [procPkg::wordWidth-1:0] resetPc = '0
) (
    input  logic                           clk,
    input  logic                           rst,
    output logic [procPkg::wordWidth-1:0]  instrAddr,
    input  logic [procPkg::wordWidth-1:0]  instr,
    output logic [procPkg::wordWidth-1:0]  paddr,
    output logic                           psel,
    output logic                           penable,
    output logic                           pwrite,
    output logic [procPkg::wordWidth-1:0]  pwdata,
    input  logic [procPkg::wordWidth-1:0]  prdata,
    input  logic                           pready,
    output logic                           halted,
    output logic                           err
);
    import procPkg::*;

    procState_t              state;
    opcode_t                 opcode;
    aluFunct_t               funct;
    logic [wordWidth-1:0]    instrReg;
    logic [wordWidth-1:0]    rsVal;
    logic [wordWidth-1:0]    rtVal;
    logic [wordWidth-1:0]    imm;
    logic [regAddrWidth-1:0] destReg;
    logic                    isMem;
    logic                    isJump;
    logic                    isHalt;
    logic                    illegal;
    logic [wordWidth-1:0]    aluOut;
    logic                    branchTaken;
    logic [wordWidth-1:0]    branchTarget;
    logic                    memDone;
    logic                    wbEn;
    logic [wordWidth-1:0]    wbData;

    fetchControl #(.resetPc(resetPc)) fetchInst (
        .clk(clk), .rst(rst), .instr(instr),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .isMem(isMem), .isJump(isJump), .illegal(illegal), .isHalt(isHalt),
        .memDone(memDone), .instrAddr(instrAddr), .instrReg(instrReg),
        .state(state), .halted(halted), .err(err)
    );

    decode decodeInst (
        .clk(clk), .rst(rst), .instrReg(instrReg), .state(state),
        .wbData(wbData), .wbEn(wbEn), .opcode(opcode), .funct(funct),
        .rsVal(rsVal), .rtVal(rtVal), .imm(imm), .destReg(destReg),
        .isMem(isMem), .isStore(), .isBranch(), .isJump(isJump),
        .isHalt(isHalt), .illegal(illegal)
    );

    execute executeInst (
        .clk(clk), .rst(rst), .state(state), .opcode(opcode), .funct(funct),
        .rsVal(rsVal), .rtVal(rtVal), .imm(imm), .pc(instrAddr),   // PC seen on fetch port
        .aluOut(aluOut), .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    resultStage resultInst (
        .clk(clk), .rst(rst), .state(state), .opcode(opcode),
        .aluOut(aluOut), .rtVal(rtVal), .prdata(prdata), .pready(pready),
        .paddr(paddr), .pwdata(pwdata), .psel(psel), .penable(penable),
        .pwrite(pwrite), .memDone(memDone), .wbEn(wbEn), .wbData(wbData)
    );

endmodule

//--- source/procPkg.sv
// ==========================================================================
// Processor core shared types
// ==========================================================================
package procPkg;

    localparam int wordWidth    = 16;  // Data, address and instruction width
    localparam int regAddrWidth = 3;   // Eight registers
    localparam int regCount     = 1 << regAddrWidth;
    localparam int opcodeWidth  = 5;

    // Major opcodes in bits 15:11, anything else traps
    typedef enum logic [opcodeWidth-1:0] {
        opHalt = 5'b00000,
        opJ    = 5'b00100,
        opAddi = 5'b01000,
        opBeqz = 5'b01100,
        opBnez = 5'b01101,
        opSt   = 5'b10000,
        opLd   = 5'b10001,
        opLbi  = 5'b11000,
        opAlu  = 5'b11011
    } opcode_t;

    // Function field of opAlu, bits 1:0
    typedef enum logic [1:0] {
        fnAdd = 2'b00,
        fnSub = 2'b01,
        fnAnd = 2'b11,
        fnXor = 2'b10
    } aluFunct_t;

    // Multicycle sequencer, one instruction in flight
    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stExecute   = 3'd2,
        stMemory    = 3'd3,
        stWriteback = 3'd4,
        stHalted    = 3'd5
    } procState_t;

endpackage

//--- source/resultStage.sv
// ==========================================================================
// APB data port and writeback select
// ==========================================================================
module resultStage (
    input  logic                           clk,
    input  logic                           rst,
    input  procPkg::procState_t            state,
    input  procPkg::opcode_t               opcode,
    input  logic [procPkg::wordWidth-1:0]  aluOut,
    input  logic [procPkg::wordWidth-1:0]  rtVal,
    input  logic [procPkg::wordWidth-1:0]  prdata,
    input  logic                           pready,
    output logic [procPkg::wordWidth-1:0]  paddr,
    output logic [procPkg::wordWidth-1:0]  pwdata,
    output logic                           psel,
    output logic                           penable,
    output logic                           pwrite,
    output logic                           memDone,
    output logic                           wbEn,
    output logic [procPkg::wordWidth-1:0]  wbData
);
    import procPkg::*;

    typedef enum logic [1:0] {
        apbIdle,
        apbSetup,
        apbAccess
    } apbState_t;

    apbState_t            apbState;
    logic                 memOp;
    logic [wordWidth-1:0] loadData;     // Captured prdata

    assign memOp = (opcode == opLd) || (opcode == opSt);

    // Bus signals stay steady while pready is low
    assign paddr   = aluOut;                    // Registered in execute
    assign pwdata  = rtVal;
    assign psel    = (apbState != apbIdle);
    assign penable = (apbState == apbAccess);
    assign pwrite  = psel && (opcode == opSt);
    assign memDone = penable && pready;

    // Setup begins on the first cycle of stMemory
    always_ff @(posedge clk) begin
        if (rst) begin
            apbState <= apbIdle;
        end else begin
            case (apbState)
                apbIdle: begin
                    if (state == stExecute && memOp) begin
                        apbState <= apbSetup;
                    end
                end
                apbSetup:  apbState <= apbAccess;
                apbAccess: begin
                    if (pready) begin           // Completes on first ready access
                        apbState <= apbIdle;
                    end
                end
                default:   apbState <= apbIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (memDone && !pwrite) begin
            loadData <= prdata;
        end
    end

    // Writeback value and enable
    assign wbData = (opcode == opLd) ? loadData : aluOut;

    always_comb begin
        wbEn = 1'b0;
        if (state == stWriteback) begin
            case (opcode)
                opAlu, opAddi, opLbi, opLd: wbEn = 1'b1;
                default:                    wbEn = 1'b0;
            endcase
        end
    end

endmodule
